//--- include/ntm_settings.svh
/*
 * Global sizing for the NTM multiplication engine
 * Word width, Q8.8 fraction bits, loop index width, multiplier depth
 */
`ifndef NTM_SETTINGS_SVH
`define NTM_SETTINGS_SVH

// Operand and result word, Q8.8 signed
`define NTM_DATA_SIZE 16

// Fraction bits of the fixed-point format
`define NTM_FRAC_BITS 8

// One dimension or loop index, dims 1..15
`define NTM_CONTROL_SIZE 4

// Register stages inside the multiplier
`define NTM_MUL_STAGES 2

`endif

//--- hw/ntm_stream_pkg.sv
/*
 * Stream payload types
 * Q8.8 word, operand pair, rounded product, tagged result
 */
`include "ntm_settings.svh"

package ntm_stream_pkg;

  // Signed Q8.8 word
  typedef logic signed [`NTM_DATA_SIZE-1:0] ntm_data_t;

  // A and B joined for the multiplier
  typedef struct packed {
    ntm_data_t a;
    ntm_data_t b;
  } operand_pair_t;

  // Rounded and clamped product
  typedef struct packed {
    ntm_data_t value;
    logic      saturated;
  } product_t;

  // Product plus end-of-loop tags
  typedef struct packed {
    product_t product;
    logic     end_scalar;
    logic     end_vector;
    logic     end_matrix;
  } result_t;

endpackage

//--- hw/ntm_control_pkg.sv
/*
 * Job control types
 * Loop index, job dimensions, controller states
 */
`include "ntm_settings.svh"

package ntm_control_pkg;

  // One loop counter
  typedef logic [`NTM_CONTROL_SIZE-1:0] loop_index_t;

  // Rows I, vectors J, length L
  typedef struct packed {
    loop_index_t size_i;
    loop_index_t size_j;
    loop_index_t length;
  } matrix_dims_t;

  // Idle, loading, draining
  typedef enum logic [1:0] {
    CTRL_IDLE = 2'd0,
    CTRL_RUN  = 2'd1,
    CTRL_DONE = 2'd2
  } ctrl_state_t;

endpackage

//--- hw/stream_skid_buffer.sv
/*
 * Two-entry skid buffer for a valid/ready stream
 * Payload type is a parameter, ready towards the source is registered
 */
`timescale 1ns/1ps

module stream_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     RST,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  // Skid entry, holds the beat taken while the output stalls
  logic     skid_valid;
  payload_t skid_data;

  logic in_fire;
  logic main_free;
  logic skid_valid_n;

  assign in_fire   = in_valid & in_ready;
  // Main register can take a new beat
  assign main_free = ~out_valid | out_ready;

  // Skid fills only on a stalled output, drains into main first
  assign skid_valid_n = main_free ? 1'b0 : (skid_valid | in_fire);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else begin
      if (main_free) begin
        out_valid <= skid_valid | in_fire;
      end
      skid_valid <= skid_valid_n;
      // Registered ready, one spare beat covers the delay
      in_ready   <= ~skid_valid_n;
    end
  end

  // Payload, no reset
  always_ff @(posedge CLK) begin
    if (main_free) begin
      out_data <= skid_valid ? skid_data : in_data;
    end
    if (!main_free && in_fire) begin
      skid_data <= in_data;
    end
  end

endmodule

//--- hw/matrix_operand_loader.sv
/*
 * Operand loader
 * Holds A and B separately, offers them as one pair
 */
`timescale 1ns/1ps

module matrix_operand_loader (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          load_enable,
  input  logic                          a_valid,
  input  logic                          b_valid,
  input  ntm_stream_pkg::ntm_data_t     a_data,
  input  ntm_stream_pkg::ntm_data_t     b_data,
  output logic                          a_ready,
  output logic                          b_ready,
  output logic                          pair_valid,
  output ntm_stream_pkg::operand_pair_t pair_data,
  input  logic                          pair_ready,
  output logic                          pair_fire
);

  import ntm_stream_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Operand registers
  ////////////////////////////////////////////////////////////////////////////

  ntm_data_t a_q;
  ntm_data_t b_q;
  logic      a_full;
  logic      b_full;

  // Each side takes one word per pair, any order
  assign a_ready = load_enable & ~a_full;
  assign b_ready = load_enable & ~b_full;

  // Pair offered once both sides hold a word
  assign pair_valid = a_full & b_full;
  assign pair_data  = '{a: a_q, b: b_q};
  assign pair_fire  = pair_valid & pair_ready;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      a_full <= 1'b0;
      b_full <= 1'b0;
    end else if (pair_fire) begin
      // Both slots free again
      a_full <= 1'b0;
      b_full <= 1'b0;
    end else begin
      if (a_valid && a_ready) begin
        a_full <= 1'b1;
      end
      if (b_valid && b_ready) begin
        b_full <= 1'b1;
      end
    end
  end

  // Operand words
  always_ff @(posedge CLK) begin
    if (a_valid && a_ready) begin
      a_q <= a_data;
    end
    if (b_valid && b_ready) begin
      b_q <= b_data;
    end
  end

endmodule

//--- hw/vector_multiplication.sv
/*
 * Q8.8 multiplier, two stages
 * Full product, then round half-up and saturate, whole pipe stalls together
 */
`timescale 1ns/1ps
`include "ntm_settings.svh"

module vector_multiplication (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          in_valid,
  input  ntm_stream_pkg::operand_pair_t in_data,
  output logic                          in_ready,
  output logic                          out_valid,
  output ntm_stream_pkg::product_t      out_data,
  input  logic                          out_ready
);

  import ntm_stream_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int PROD_W   = 2 * `NTM_DATA_SIZE;
  // Half an output LSB
  localparam int HALF_LSB = 1 << (`NTM_FRAC_BITS - 1);
  localparam int MAX_VAL  = (1 << (`NTM_DATA_SIZE - 1)) - 1;
  localparam int MIN_VAL  = -(1 << (`NTM_DATA_SIZE - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Stage 1
  logic                     prod_valid;
  logic signed [PROD_W-1:0] prod_q;

  // Stage 2 inputs
  logic signed [PROD_W-1:0] rounded;
  ntm_data_t                sat_value;
  logic                     sat_flag;

  logic stall;

  // Freeze everything while the result waits
  assign stall    = out_valid & ~out_ready;
  assign in_ready = ~stall;

  ////////////////////////////////////////////////////////////////////////////
  // Round and clamp
  ////////////////////////////////////////////////////////////////////////////

  // Arithmetic shift keeps the sign
  assign rounded = (prod_q + PROD_W'(HALF_LSB)) >>> `NTM_FRAC_BITS;

  always_comb begin
    sat_flag = 1'b1;
    if (rounded > PROD_W'(MAX_VAL)) begin
      sat_value = ntm_data_t'(MAX_VAL);
    end else if (rounded < PROD_W'(MIN_VAL)) begin
      sat_value = ntm_data_t'(MIN_VAL);
    end else begin
      // In range
      sat_value = rounded[`NTM_DATA_SIZE-1:0];
      sat_flag  = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prod_valid <= 1'b0;
      out_valid  <= 1'b0;
    end else if (!stall) begin
      prod_valid <= in_valid;
      out_valid  <= prod_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (!stall) begin
      // Sign-extended operands, full 32-bit product
      prod_q   <= PROD_W'(in_data.a) * PROD_W'(in_data.b);
      out_data <= '{value: sat_value, saturated: sat_flag};
    end
  end

endmodule

//--- hw/matrix_multiplication_ctrl.sv
/*
 * Job controller
 * Start and ready handling, load and result loop counters, end-of-loop tags
 */
`timescale 1ns/1ps
`include "ntm_settings.svh"

module matrix_multiplication_ctrl (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          start,
  input  ntm_control_pkg::matrix_dims_t dims,
  output logic                          ready,
  output logic                          load_enable,
  input  logic                          pair_fire,
  input  logic                          prod_valid,
  input  ntm_stream_pkg::product_t      prod_data,
  output logic                          prod_ready,
  output logic                          res_valid,
  output ntm_stream_pkg::result_t       res_data,
  input  logic                          res_ready
);

  import ntm_stream_pkg::*;
  import ntm_control_pkg::*;

  // Pairs past the loader but not yet tagged, input buffer plus multiplier
  localparam int IN_FLIGHT_MAX = `NTM_MUL_STAGES + 2;
  localparam int IN_FLIGHT_W   = $clog2(IN_FLIGHT_MAX + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  ctrl_state_t  state_q;
  matrix_dims_t dims_q;

  // Positions in i/j/l order, same layout as the dims
  matrix_dims_t load_pos;
  matrix_dims_t res_pos;

  logic [IN_FLIGHT_W-1:0] in_flight;

  logic start_ok;
  logic last_load;
  logic busy;
  logic res_fire;
  logic end_scalar;
  logic end_vector;
  logic end_matrix;

  // Advance i/j/l like three nested loops
  function automatic matrix_dims_t step_pos(matrix_dims_t pos, matrix_dims_t lim);
    matrix_dims_t nxt;
    nxt = pos;
    if (pos.length == lim.length - 1'b1) begin
      nxt.length = '0;
      if (pos.size_j == lim.size_j - 1'b1) begin
        nxt.size_j = '0;
        nxt.size_i = pos.size_i + 1'b1;
      end else begin
        nxt.size_j = pos.size_j + 1'b1;
      end
    end else begin
      nxt.length = pos.length + 1'b1;
    end
    return nxt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////////////////////

  // Zero dimensions never start a job
  assign start_ok = start && (state_q == CTRL_IDLE) && (dims.size_i != '0) &&
                    (dims.size_j != '0) && (dims.length != '0);

  assign last_load = (load_pos.size_i == dims_q.size_i - 1'b1) &&
                     (load_pos.size_j == dims_q.size_j - 1'b1) &&
                     (load_pos.length == dims_q.length - 1'b1);

  // Loading window, held back while the pipe is full
  assign load_enable = (state_q == CTRL_RUN) && (in_flight < IN_FLIGHT_W'(IN_FLIGHT_MAX));

  ////////////////////////////////////////////////////////////////////////////
  // Result tagging
  ////////////////////////////////////////////////////////////////////////////

  assign busy = (state_q != CTRL_IDLE);

  // Tags straight from the result counters
  assign end_scalar = (res_pos.length == dims_q.length - 1'b1);
  assign end_vector = end_scalar && (res_pos.size_j == dims_q.size_j - 1'b1);
  assign end_matrix = end_vector && (res_pos.size_i == dims_q.size_i - 1'b1);

  assign res_valid  = prod_valid & busy;
  assign prod_ready = res_ready & busy;
  assign res_fire   = res_valid & res_ready;
  assign res_data   = '{product: prod_data, end_scalar: end_scalar,
                        end_vector: end_vector, end_matrix: end_matrix};

  ////////////////////////////////////////////////////////////////////////////
  // State and counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q   <= CTRL_IDLE;
      ready     <= 1'b0;
      load_pos  <= '0;
      res_pos   <= '0;
      in_flight <= '0;
    end else begin
      if (pair_fire) begin
        load_pos <= step_pos(load_pos, dims_q);
      end
      if (res_fire) begin
        res_pos <= step_pos(res_pos, dims_q);
      end

      // Pair in, product out
      case ({pair_fire, res_fire})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase

      case (state_q)
        CTRL_IDLE: begin
          if (start_ok) begin
            ready    <= 1'b0;
            load_pos <= '0;
            res_pos  <= '0;
            state_q  <= CTRL_RUN;
          end
        end
        CTRL_RUN: begin
          // Last pair out of the loader
          if (pair_fire && last_load) begin
            state_q <= CTRL_DONE;
          end
        end
        CTRL_DONE: begin
          // Drain until the end-of-matrix result leaves
          if (res_fire && end_matrix) begin
            ready   <= 1'b1;
            state_q <= CTRL_IDLE;
          end
        end
        default: state_q <= CTRL_IDLE;
      endcase
    end
  end

  // Job dimensions
  always_ff @(posedge CLK) begin
    if (start_ok) begin
      dims_q <= dims;
    end
  end

endmodule

//--- hw/accelerator_matrix_multiplication.sv
/*
 * Top level of the element-wise multiplication engine
 * Loader, input buffer, multiplier, controller, output buffer
 */
`timescale 1ns/1ps

module accelerator_matrix_multiplication (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          start,
  input  ntm_control_pkg::matrix_dims_t dims,
  output logic                          ready,
  input  logic                          a_valid,
  input  ntm_stream_pkg::ntm_data_t     a_data,
  output logic                          a_ready,
  input  logic                          b_valid,
  input  ntm_stream_pkg::ntm_data_t     b_data,
  output logic                          b_ready,
  output logic                          res_valid,
  output ntm_stream_pkg::result_t       res_data,
  input  logic                          res_ready
);

  import ntm_stream_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Internal streams
  ////////////////////////////////////////////////////////////////////////////

  // Loader to input buffer
  logic          pair_valid;
  operand_pair_t pair_data;
  logic          pair_ready;
  logic          pair_fire;
  logic          load_enable;

  // Input buffer to multiplier
  logic          op_valid;
  operand_pair_t op_data;
  logic          op_ready;

  // Multiplier to controller
  logic          prod_valid;
  product_t      prod_data;
  logic          prod_ready;

  // Controller to output buffer
  logic          tag_valid;
  result_t       tag_data;
  logic          tag_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////////////////////

  matrix_operand_loader loader_i (
    .CLK        (CLK),
    .RST        (RST),
    .load_enable(load_enable),
    .a_valid    (a_valid),
    .b_valid    (b_valid),
    .a_data     (a_data),
    .b_data     (b_data),
    .a_ready    (a_ready),
    .b_ready    (b_ready),
    .pair_valid (pair_valid),
    .pair_data  (pair_data),
    .pair_ready (pair_ready),
    .pair_fire  (pair_fire)
  );

  stream_skid_buffer #(
    .payload_t(operand_pair_t)
  ) in_buffer_i (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (pair_valid),
    .in_data  (pair_data),
    .in_ready (pair_ready),
    .out_valid(op_valid),
    .out_data (op_data),
    .out_ready(op_ready)
  );

  vector_multiplication multiplier_i (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (op_valid),
    .in_data  (op_data),
    .in_ready (op_ready),
    .out_valid(prod_valid),
    .out_data (prod_data),
    .out_ready(prod_ready)
  );

  matrix_multiplication_ctrl ctrl_i (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .dims       (dims),
    .ready      (ready),
    .load_enable(load_enable),
    .pair_fire  (pair_fire),
    .prod_valid (prod_valid),
    .prod_data  (prod_data),
    .prod_ready (prod_ready),
    .res_valid  (tag_valid),
    .res_data   (tag_data),
    .res_ready  (tag_ready)
  );

  // Result port buffer
  stream_skid_buffer #(
    .payload_t(result_t)
  ) out_buffer_i (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (tag_valid),
    .in_data  (tag_data),
    .in_ready (tag_ready),
    .out_valid(res_valid),
    .out_data (res_data),
    .out_ready(res_ready)
  );

endmodule

//--- dv/tb_accelerator_matrix_multiplication.sv
/*
 * Directed testbench for the element-wise multiplication engine
 * LFSR stimulus, Q8.8 and loop tag reference model, compare tasks, watchdog
 */
`timescale 1ns/1ps
`include "ntm_settings.svh"

module tb_accelerator_matrix_multiplication;

  import ntm_stream_pkg::*;
  import ntm_control_pkg::*;

  localparam int CLK_PERIOD  = 100;
  // Element count of all jobs together, 1 + 12 + 10 + 60 + 12
  localparam int TOTAL_ELEMS = 95;
  localparam int WATCHDOG_CYCLES = 20 * TOTAL_ELEMS + 20 * `NTM_MUL_STAGES + 200;

  logic         CLK;
  logic         RST;
  logic         start;
  matrix_dims_t dims;
  logic         ready;
  logic         a_valid;
  ntm_data_t    a_data;
  logic         a_ready;
  logic         b_valid;
  ntm_data_t    b_data;
  logic         b_ready;
  logic         res_valid;
  result_t      res_data;
  logic         res_ready;

  logic [31:0]  lfsr_q;
  int           checks;
  int           errors;

  // Operands of the next job in send order
  ntm_data_t    op_a[$];
  ntm_data_t    op_b[$];

  accelerator_matrix_multiplication dut_i (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .dims     (dims),
    .ready    (ready),
    .a_valid  (a_valid),
    .a_data   (a_data),
    .a_ready  (a_ready),
    .b_valid  (b_valid),
    .b_data   (b_data),
    .b_ready  (b_ready),
    .res_valid(res_valid),
    .res_data (res_data),
    .res_ready(res_ready)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // One step per bit taken
  function automatic logic [31:0] lfsr_word(input int width);
    logic [31:0] v;
    int          n;
    v = '0;
    for (n = 0; n < width; n++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic matrix_dims_t make_dims(input int i, input int j, input int l);
    matrix_dims_t d;
    d.size_i = loop_index_t'(i);
    d.size_j = loop_index_t'(j);
    d.length = loop_index_t'(l);
    return d;
  endfunction

  // Q8.8 product with half-up rounding and clamp, tags from element index k
  function automatic result_t expected_result(input ntm_data_t a, input ntm_data_t b,
                                              input int k, input matrix_dims_t jd);
    longint  p;
    longint  r;
    longint  max_v;
    int      len;
    int      nj;
    result_t e;
    len   = int'(jd.length);
    nj    = int'(jd.size_j);
    max_v = (longint'(1) << (`NTM_DATA_SIZE - 1)) - 1;
    p = longint'(a) * longint'(b);
    r = (p + (longint'(1) << (`NTM_FRAC_BITS - 1))) >>> `NTM_FRAC_BITS;
    e.product.saturated = (r > max_v) || (r < -max_v - 1);
    if (r > max_v) begin
      r = max_v;
    end else if (r < -max_v - 1) begin
      r = -max_v - 1;
    end
    e.product.value = ntm_data_t'(r);
    e.end_scalar = (k % len) == len - 1;
    e.end_vector = e.end_scalar && ((k / len) % nj) == nj - 1;
    e.end_matrix = e.end_vector && (k / (len * nj)) == int'(jd.size_i) - 1;
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // Fields shown as value/saturated/tags
  task automatic check_result(input result_t got, input result_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error at %0t: res_data got %h/%b/%b%b%b expected %h/%b/%b%b%b",
               $time, got.product.value, got.product.saturated, got.end_scalar,
               got.end_vector, got.end_matrix, want.product.value, want.product.saturated,
               want.end_scalar, want.end_vector, want.end_matrix);
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error at %0t: %s got %b, expected %b", $time, name, got, want);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Job driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic push_pair(input ntm_data_t a, input ntm_data_t b);
    op_a.push_back(a);
    op_b.push_back(b);
  endtask

  // Mixed magnitudes so only some products clamp
  task automatic fill_random(input int count);
    logic [31:0] raw;
    int          k;
    op_a.delete();
    op_b.delete();
    for (k = 0; k < count; k++) begin
      raw = lfsr_word(32);
      op_a.push_back(ntm_data_t'(raw[15:0]) >>> (3 * int'(lfsr_word(2))));
      op_b.push_back(ntm_data_t'(raw[31:16]) >>> (3 * int'(lfsr_word(2))));
    end
  endtask

  // One start pulse, then both operand streams and the result port each cycle
  task automatic run_job(input matrix_dims_t jd, input bit random_flow, input bit restart_mid);
    result_t exp_q[$];
    int      total;
    int      limit;
    int      a_idx;
    int      b_idx;
    int      r_idx;
    int      cycle;
    logic    a_fire;
    logic    b_fire;
    total = int'(jd.size_i) * int'(jd.size_j) * int'(jd.length);
    limit = 20 * total + 50;
    for (int k = 0; k < total; k++) begin
      exp_q.push_back(expected_result(op_a[k], op_b[k], k, jd));
    end
    a_idx  = 0;
    b_idx  = 0;
    r_idx  = 0;
    cycle  = 0;
    a_fire = 1'b0;
    b_fire = 1'b0;
    @(negedge CLK);
    start = 1'b1;
    dims  = jd;
    @(negedge CLK);
    start = 1'b0;
    check_ready("ready", ready, 1'b0);
    while (r_idx < total && cycle < limit) begin
      // Ready levels are state only, so a fire decided here lands on the next edge
      if (a_fire) begin
        a_idx++;
        a_valid = 1'b0;
      end
      if (!a_valid && a_idx < total && (!random_flow || lfsr_word(2) != 0)) begin
        a_valid = 1'b1;
        a_data  = op_a[a_idx];
      end
      a_fire = a_valid && a_ready;
      if (b_fire) begin
        b_idx++;
        b_valid = 1'b0;
      end
      if (!b_valid && b_idx < total && (!random_flow || lfsr_word(2) != 0)) begin
        b_valid = 1'b1;
        b_data  = op_b[b_idx];
      end
      b_fire = b_valid && b_ready;
      // Second start with other dims while busy
      start = restart_mid && (cycle == 3);
      if (start) begin
        dims = make_dims(15, 15, 15);
      end
      // Last result may wait in the output buffer behind one other
      if (total - r_idx > 2) begin
        check_ready("ready", ready, 1'b0);
      end
      res_ready = !random_flow || (lfsr_word(2) != 0);
      if (res_valid && res_ready) begin
        check_result(res_data, exp_q[r_idx]);
        r_idx++;
      end
      @(negedge CLK);
      cycle++;
    end
    a_valid   = 1'b0;
    b_valid   = 1'b0;
    start     = 1'b0;
    res_ready = 1'b1;
    if (r_idx < total) begin
      errors++;
      $display("job stalled: only %0d of %0d results came out", r_idx, total);
    end else begin
      check_ready("ready", ready, 1'b1);
      // No extra or repeated results and no new load
      repeat (3) begin
        check_ready("res_valid", res_valid, 1'b0);
        check_ready("a_ready", a_ready, 1'b0);
        @(negedge CLK);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic single_element_job();
    @(negedge CLK);
    check_ready("ready", ready, 1'b0);
    check_ready("a_ready", a_ready, 1'b0);
    check_ready("b_ready", b_ready, 1'b0);
    check_ready("res_valid", res_valid, 1'b0);
    fill_random(1);
    run_job(make_dims(1, 1, 1), 1'b0, 1'b0);
  endtask

  task automatic loop_tag_job();
    fill_random(12);
    run_job(make_dims(2, 3, 2), 1'b0, 1'b0);
  endtask

  // Halfway cases, signs, both clamp directions and the exact limits
  task automatic rounding_and_saturation();
    op_a.delete();
    op_b.delete();
    push_pair(16'h0180, 16'h0180);
    push_pair(16'h0001, 16'h0080);
    push_pair(16'hffff, 16'h0080);
    push_pair(16'hffff, 16'h0180);
    push_pair(16'hfe00, 16'h0300);
    push_pair(16'h7fff, 16'h7fff);
    push_pair(16'h8000, 16'h7fff);
    push_pair(16'h1000, 16'h0800);
    push_pair(16'h0fff, 16'h0800);
    push_pair(16'hf000, 16'h0800);
    run_job(make_dims(1, 2, 5), 1'b0, 1'b0);
  endtask

  task automatic stalled_streams();
    fill_random(60);
    run_job(make_dims(3, 4, 5), 1'b1, 1'b0);
  endtask

  // Ready is high from the job before and must stay high
  task automatic ignored_starts();
    @(negedge CLK);
    start = 1'b1;
    dims  = make_dims(2, 0, 3);
    @(negedge CLK);
    start = 1'b0;
    repeat (4) begin
      check_ready("a_ready", a_ready, 1'b0);
      check_ready("b_ready", b_ready, 1'b0);
      check_ready("ready", ready, 1'b1);
      @(negedge CLK);
    end
    fill_random(12);
    run_job(make_dims(2, 3, 2), 1'b0, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    CLK       = 1'b0;
    RST       = 1'b1;
    start     = 1'b0;
    dims      = '0;
    a_valid   = 1'b0;
    a_data    = '0;
    b_valid   = 1'b0;
    b_data    = '0;
    res_ready = 1'b1;
    lfsr_q    = 32'h00123c8f;
    checks    = 0;
    errors    = 0;
    repeat (3) @(negedge CLK);
    RST = 1'b0;
    single_element_job();
    loop_tag_job();
    rounding_and_saturation();
    stalled_streams();
    ignored_starts();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- build.f
+incdir+include
hw/ntm_stream_pkg.sv
hw/ntm_control_pkg.sv
hw/stream_skid_buffer.sv
hw/matrix_operand_loader.sv
hw/vector_multiplication.sv
hw/matrix_multiplication_ctrl.sv
hw/accelerator_matrix_multiplication.sv
dv/tb_accelerator_matrix_multiplication.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator
# Exit status follows the verdict found in the log

set -e
cd "$(dirname "$0")"

TOP=tb_accelerator_matrix_multiplication
LOG=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module "$TOP" \
  -f build.f \
  -o "V$TOP"

./obj_dir/"V$TOP" > "$LOG" 2>&1
cat "$LOG"

if grep -qx "Done: no errors" "$LOG"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
